// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_simd_alu -f vlog.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^Verification passed$" sim.log; then
  exit 0
fi
exit 1

// ==== source/alu_csr.sv ====
// Rounding-mode register and sticky saturation flag, written by the config port
`timescale 1ns/1ns

module alu_csr (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      cfg_we_i,
  input  simd_alu_pkg::cfg_t        cfg_i,
  input  logic                      sat_valid_i,
  input  simd_alu_pkg::elem_flags_t sat_i,
  output simd_alu_pkg::vxrm_e       vxrm_o,
  output logic                      vxsat_o
);

  simd_alu_pkg::vxrm_e vxrm_q;
  logic                vxsat_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vxrm_q <= simd_alu_pkg::RNU;
    end else if (cfg_we_i) begin
      vxrm_q <= cfg_i.vxrm;
    end
  end

  // Sticky OR over issued results, clear has priority
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vxsat_q <= 1'b0;
    end else if (cfg_we_i && cfg_i.vxsat_clr) begin
      vxsat_q <= 1'b0;
    end else if (sat_valid_i && (|sat_i)) begin
      vxsat_q <= 1'b1;
    end
  end

  assign vxrm_o  = vxrm_q;
  assign vxsat_o = vxsat_q;

endmodule

// ==== source/op_queue.sv ====
// Request FIFO in front of the ALU, returns one upstream credit per popped entry
`timescale 1ns/1ns

module op_queue #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   push_i,
  input  simd_alu_pkg::alu_req_t push_data_i,
  input  logic                   pop_i,
  output simd_alu_pkg::alu_req_t head_o,
  output logic                   head_valid_o,
  output logic                   credit_o
);

  localparam int unsigned PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CntW = $clog2(QueueDepth + 1);

  simd_alu_pkg::alu_req_t mem [QueueDepth];
  logic [PtrW-1:0]        wr_ptr_q;
  logic [PtrW-1:0]        rd_ptr_q;
  logic [CntW-1:0]        count_q;
  logic                   credit_q;

  ////////////////////
  // Pointers
  ////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(QueueDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(QueueDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q  <= count_q + CntW'(push_i) - CntW'(pop_i);
      credit_q <= pop_i;
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  assign head_o       = mem[rd_ptr_q];
  assign head_valid_o = (count_q != '0);
  assign credit_o     = credit_q;

endmodule

// ==== source/result_stage.sv ====
// Result select and output register with the downstream credit counter
`timescale 1ns/1ns

module result_stage #(
  parameter int unsigned OutCredits = 2
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      head_valid_i,
  input  simd_alu_pkg::alu_op_e     head_op_i,
  input  simd_alu_pkg::data_t       arith_i,
  input  simd_alu_pkg::elem_flags_t arith_sat_i,
  input  simd_alu_pkg::data_t       logic_i,
  input  logic                      resp_credit_i,
  output logic                      pop_o,
  output logic                      sat_valid_o,
  output logic                      resp_valid_o,
  output simd_alu_pkg::alu_resp_t   resp_o
);

  localparam int unsigned CntW = $clog2(OutCredits + 1);

  logic [CntW-1:0]         credit_q;
  logic                    resp_valid_q;
  logic                    is_logic;
  simd_alu_pkg::alu_resp_t resp_d;
  simd_alu_pkg::alu_resp_t resp_q;

  ////////////////////
  // Credits
  ////////////////////

  // A response on the port still holds its credit
  assign pop_o       = head_valid_i & (credit_q > CntW'(resp_valid_q));
  assign sat_valid_o = pop_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_q     <= CntW'(OutCredits);
      resp_valid_q <= 1'b0;
    end else begin
      credit_q     <= credit_q - CntW'(resp_valid_q) + CntW'(resp_credit_i);
      resp_valid_q <= pop_o;
    end
  end

  ////////////////////
  // Result select
  ////////////////////

  assign is_logic = head_op_i inside {
    simd_alu_pkg::VAND, simd_alu_pkg::VOR, simd_alu_pkg::VXOR,
    simd_alu_pkg::VMINU, simd_alu_pkg::VMIN, simd_alu_pkg::VMAXU, simd_alu_pkg::VMAX,
    simd_alu_pkg::VMSEQ, simd_alu_pkg::VMSLTU, simd_alu_pkg::VMSLT
  };

  assign resp_d.result = is_logic ? logic_i : arith_i;
  assign resp_d.vxsat  = is_logic ? '0 : arith_sat_i;

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      resp_q <= resp_d;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

endmodule

// ==== source/simd_adder.sv ====
// Add, subtract, saturating and averaging ops on each element of the 64-bit word
`timescale 1ns/1ns

module simd_adder (
  input  simd_alu_pkg::alu_req_t    req_i,
  input  simd_alu_pkg::vxrm_e       vxrm_i,
  output simd_alu_pkg::data_t       result_o,
  output simd_alu_pkg::elem_flags_t vxsat_o
);

  localparam int unsigned DataWidth = simd_alu_pkg::DataWidth;
  localparam int unsigned NumBytes  = simd_alu_pkg::NumBytes;

  logic                      is_signed;
  logic [3:0][DataWidth-1:0] res_w;
  logic [3:0][NumBytes-1:0]  sat_w;

  assign is_signed = req_i.op inside {simd_alu_pkg::VSADD, simd_alu_pkg::VSSUB,
                                      simd_alu_pkg::VAADD};

  // One copy per element width, the vew field picks the result
  for (genvar g = 0; g < 4; g++) begin : gen_width
    localparam int unsigned W = 8 << g;

    for (genvar e = 0; e < DataWidth / W; e++) begin : gen_elem
      logic [W:0]   xa;
      logic [W:0]   xb;
      logic [W:0]   sum;
      logic [W:0]   diff;
      logic [W:0]   rdiff;
      logic [W-1:0] res;
      logic         sat;
      logic         d0;
      logic         k0;
      logic         rnd;

      // Extend by one bit, sign or zero
      assign xa    = {is_signed & req_i.opa[e*W+W-1], req_i.opa[e*W +: W]};
      assign xb    = {is_signed & req_i.opb[e*W+W-1], req_i.opb[e*W +: W]};
      assign sum   = xa + xb;
      assign diff  = xb - xa;
      assign rdiff = xa - xb;

      // Dropped and kept bit of the halved sum
      assign d0 = sum[0];
      assign k0 = sum[1];

      always_comb begin
        unique case (vxrm_i)
          simd_alu_pkg::RNU: rnd = d0;
          simd_alu_pkg::RNE: rnd = d0 & k0;
          simd_alu_pkg::RDN: rnd = 1'b0;
          default:           rnd = d0 & ~k0;
        endcase
      end

      always_comb begin
        res = sum[W-1:0];
        sat = 1'b0;
        unique case (req_i.op)
          simd_alu_pkg::VSUB:  res = diff[W-1:0];
          simd_alu_pkg::VRSUB: res = rdiff[W-1:0];
          simd_alu_pkg::VSADDU: begin
            sat = sum[W];
            res = sat ? '1 : sum[W-1:0];
          end
          simd_alu_pkg::VSADD: begin
            sat = sum[W] ^ sum[W-1];
            res = sat ? {sum[W], {(W-1){~sum[W]}}} : sum[W-1:0];
          end
          simd_alu_pkg::VSSUBU: begin
            sat = diff[W];
            res = sat ? '0 : diff[W-1:0];
          end
          simd_alu_pkg::VSSUB: begin
            sat = diff[W] ^ diff[W-1];
            res = sat ? {diff[W], {(W-1){~diff[W]}}} : diff[W-1:0];
          end
          simd_alu_pkg::VAADDU, simd_alu_pkg::VAADD: res = sum[W:1] + W'(rnd);
          default: ;
        endcase
      end

      assign res_w[g][e*W +: W]         = res;
      assign sat_w[g][e*(W/8) +: (W/8)] = {(W/8){sat}};
    end
  end

  assign result_o = res_w[req_i.vew];
  assign vxsat_o  = sat_w[req_i.vew];

endmodule

// ==== source/simd_alu_pkg.sv ====
// Shared types of the pipelined SIMD ALU, referenced by scoped name from every block
package simd_alu_pkg;

  localparam int unsigned DataWidth = 64;
  localparam int unsigned NumBytes  = DataWidth / 8;

  typedef logic [DataWidth-1:0] data_t;
  // One bit per byte lane, wider elements set all their bytes
  typedef logic [NumBytes-1:0]  elem_flags_t;

  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  // Fixed-point rounding mode
  typedef enum logic [1:0] {
    RNU,
    RNE,
    RDN,
    ROD
  } vxrm_e;

  typedef enum logic [4:0] {
    VADD, VSUB, VRSUB,
    VSADDU, VSADD, VSSUBU, VSSUB,
    VAADDU, VAADD,
    VAND, VOR, VXOR,
    VMINU, VMIN, VMAXU, VMAX,
    VMSEQ, VMSLTU, VMSLT
  } alu_op_e;

  typedef struct packed {
    alu_op_e op;
    vew_e    vew;
    data_t   opa;
    data_t   opb;
  } alu_req_t;

  typedef struct packed {
    data_t       result;
    elem_flags_t vxsat;
  } alu_resp_t;

  typedef struct packed {
    vxrm_e vxrm;
    logic  vxsat_clr;
  } cfg_t;

endpackage

// ==== source/simd_alu_top.sv ====
// Top level of the SIMD ALU lane, credit flow on both the request and result side
`timescale 1ns/1ns

module simd_alu_top #(
  parameter int unsigned QueueDepth = 4,
  parameter int unsigned OutCredits = 2
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    req_valid_i,
  input  simd_alu_pkg::alu_req_t  req_i,
  output logic                    req_credit_o,
  output logic                    resp_valid_o,
  output simd_alu_pkg::alu_resp_t resp_o,
  input  logic                    resp_credit_i,
  input  logic                    cfg_we_i,
  input  simd_alu_pkg::cfg_t      cfg_i,
  output logic                    vxsat_o
);

  simd_alu_pkg::alu_req_t    head;
  logic                      head_valid;
  logic                      pop;
  logic                      sat_valid;
  simd_alu_pkg::data_t       arith_res;
  simd_alu_pkg::elem_flags_t arith_sat;
  simd_alu_pkg::data_t       logic_res;
  simd_alu_pkg::vxrm_e       vxrm;

  op_queue #(
    .QueueDepth (QueueDepth)
  ) u_queue (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .push_i       (req_valid_i),
    .push_data_i  (req_i),
    .pop_i        (pop),
    .head_o       (head),
    .head_valid_o (head_valid),
    .credit_o     (req_credit_o)
  );

  simd_adder u_adder (
    .req_i    (head),
    .vxrm_i   (vxrm),
    .result_o (arith_res),
    .vxsat_o  (arith_sat)
  );

  simd_logic_cmp u_logic_cmp (
    .req_i    (head),
    .result_o (logic_res)
  );

  result_stage #(
    .OutCredits (OutCredits)
  ) u_result (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .head_valid_i  (head_valid),
    .head_op_i     (head.op),
    .arith_i       (arith_res),
    .arith_sat_i   (arith_sat),
    .logic_i       (logic_res),
    .resp_credit_i (resp_credit_i),
    .pop_o         (pop),
    .sat_valid_o   (sat_valid),
    .resp_valid_o  (resp_valid_o),
    .resp_o        (resp_o)
  );

  alu_csr u_csr (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_i       (cfg_i),
    .sat_valid_i (sat_valid),
    .sat_i       (arith_sat),
    .vxrm_o      (vxrm),
    .vxsat_o     (vxsat_o)
  );

endmodule

// ==== source/simd_logic_cmp.sv ====
// Bitwise, min/max and compare ops of the SIMD ALU, per element where it matters
`timescale 1ns/1ns

module simd_logic_cmp (
  input  simd_alu_pkg::alu_req_t req_i,
  output simd_alu_pkg::data_t    result_o
);

  localparam int unsigned DataWidth = simd_alu_pkg::DataWidth;

  logic                      is_signed;
  logic                      is_max;
  logic [3:0][DataWidth-1:0] res_w;

  assign is_signed = req_i.op inside {simd_alu_pkg::VMIN, simd_alu_pkg::VMAX,
                                      simd_alu_pkg::VMSLT};
  assign is_max    = req_i.op inside {simd_alu_pkg::VMAX, simd_alu_pkg::VMAXU};

  for (genvar g = 0; g < 4; g++) begin : gen_width
    localparam int unsigned W = 8 << g;

    for (genvar e = 0; e < DataWidth / W; e++) begin : gen_elem
      logic [W-1:0] a;
      logic [W-1:0] b;
      logic [W-1:0] res;
      logic         less;
      logic         equal;

      assign a = req_i.opa[e*W +: W];
      assign b = req_i.opb[e*W +: W];

      // b < a, as the compare opcodes define it
      assign less  = $signed({is_signed & b[W-1], b}) < $signed({is_signed & a[W-1], a});
      assign equal = (a == b);

      always_comb begin
        unique case (req_i.op)
          simd_alu_pkg::VMSEQ:                     res = W'(equal);
          simd_alu_pkg::VMSLTU, simd_alu_pkg::VMSLT: res = W'(less);
          default:                                 res = (less ^ is_max) ? b : a;
        endcase
      end

      assign res_w[g][e*W +: W] = res;
    end
  end

  always_comb begin
    unique case (req_i.op)
      simd_alu_pkg::VAND: result_o = req_i.opa & req_i.opb;
      simd_alu_pkg::VOR:  result_o = req_i.opa | req_i.opb;
      simd_alu_pkg::VXOR: result_o = req_i.opa ^ req_i.opb;
      default:            result_o = res_w[req_i.vew];
    endcase
  end

endmodule

// ==== verif/alu_checker.sv ====
// Reference model and in-order comparator watching the ports of the SIMD ALU
`timescale 1ns/1ns

module alu_checker (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    req_valid_i,
  input  simd_alu_pkg::alu_req_t  req_i,
  input  logic [1:0]              test_id_i,
  input  logic                    cfg_we_i,
  input  simd_alu_pkg::cfg_t      cfg_i,
  input  logic                    resp_valid_i,
  input  simd_alu_pkg::alu_resp_t resp_i,
  input  logic                    req_credit_i,
  input  logic                    vxsat_i,
  output int                      errors_o,
  output int                      resp_count_o,
  output int                      credit_count_o
);

  typedef struct packed {
    simd_alu_pkg::alu_req_t req;
    simd_alu_pkg::vxrm_e    rm;
    logic [1:0]             tid;
  } pend_t;

  pend_t               pend_q[$];
  simd_alu_pkg::vxrm_e rm_model;
  logic                sticky;
  int                  errors;
  int                  cyc;
  int                  first_req_cyc;
  logic                seen_req;
  logic                seen_resp;

  function automatic string test_name(input logic [1:0] tid);
    case (tid)
      2'd0:    return "wrap";
      2'd1:    return "saturate";
      2'd2:    return "average";
      default: return "logic_cmp";
    endcase
  endfunction

  // Expected response per element in 65-bit arithmetic
  function automatic simd_alu_pkg::alu_resp_t model(input simd_alu_pkg::alu_req_t r,
                                                    input simd_alu_pkg::vxrm_e rm);
    simd_alu_pkg::alu_resp_t o;
    int          w;
    logic [64:0] msk;
    logic [64:0] m1;
    logic [64:0] top;
    logic [64:0] a;
    logic [64:0] b;
    logic [64:0] xa;
    logic [64:0] xb;
    logic [64:0] s;
    logic [64:0] d;
    logic [64:0] v;
    logic        sg;
    logic        sat;
    logic        less;
    logic        rnd;
    o   = '0;
    w   = 8 << r.vew;
    msk = (65'd1 << w) - 65'd1;
    m1  = (msk << 1) | 65'd1;
    top = 65'd1 << (w - 1);
    sg  = r.op inside {simd_alu_pkg::VSADD, simd_alu_pkg::VSSUB, simd_alu_pkg::VAADD,
                       simd_alu_pkg::VMIN, simd_alu_pkg::VMAX, simd_alu_pkg::VMSLT};
    for (int e = 0; e < 64 / w; e++) begin
      a    = (65'(r.opa) >> (e * w)) & msk;
      b    = (65'(r.opb) >> (e * w)) & msk;
      xa   = (sg && a[w-1]) ? (a | (65'd1 << w)) : a;
      xb   = (sg && b[w-1]) ? (b | (65'd1 << w)) : b;
      s    = (xa + xb) & m1;
      d    = (xb - xa) & m1;
      sat  = 1'b0;
      less = sg ? ((b ^ top) < (a ^ top)) : (b < a);
      case (rm)
        simd_alu_pkg::RNU: rnd = s[0];
        simd_alu_pkg::RNE: rnd = s[0] & s[1];
        simd_alu_pkg::RDN: rnd = 1'b0;
        default:           rnd = s[0] & ~s[1];
      endcase
      case (r.op)
        simd_alu_pkg::VSUB:   v = d;
        simd_alu_pkg::VRSUB:  v = (xa - xb) & m1;
        simd_alu_pkg::VSADDU: begin
          sat = s[w];
          v   = sat ? msk : s;
        end
        simd_alu_pkg::VSADD: begin
          sat = s[w] ^ s[w-1];
          v   = !sat ? s : (s[w] ? top : (msk >> 1));
        end
        simd_alu_pkg::VSSUBU: begin
          sat = d[w];
          v   = sat ? 65'd0 : d;
        end
        simd_alu_pkg::VSSUB: begin
          sat = d[w] ^ d[w-1];
          v   = !sat ? d : (d[w] ? top : (msk >> 1));
        end
        simd_alu_pkg::VAADDU, simd_alu_pkg::VAADD: v = (s >> 1) + 65'(rnd);
        simd_alu_pkg::VMINU, simd_alu_pkg::VMIN:   v = less ? b : a;
        simd_alu_pkg::VMAXU, simd_alu_pkg::VMAX:   v = less ? a : b;
        simd_alu_pkg::VMSEQ:                       v = 65'(a == b);
        simd_alu_pkg::VMSLTU, simd_alu_pkg::VMSLT: v = 65'(less);
        default:                                   v = s;
      endcase
      o.result = o.result | 64'((v & msk) << (e * w));
      if (sat) begin
        o.vxsat = o.vxsat | 8'(((1 << (w / 8)) - 1) << (e * w / 8));
      end
    end
    case (r.op)
      simd_alu_pkg::VAND: o.result = r.opa & r.opb;
      simd_alu_pkg::VOR:  o.result = r.opa | r.opb;
      simd_alu_pkg::VXOR: o.result = r.opa ^ r.opb;
      default: ;
    endcase
    return o;
  endfunction

  initial begin
    rm_model       = simd_alu_pkg::RNU;
    sticky         = 1'b0;
    errors         = 0;
    cyc            = 0;
    first_req_cyc  = 0;
    seen_req       = 1'b0;
    seen_resp      = 1'b0;
    resp_count_o   = 0;
    credit_count_o = 0;
  end

  assign errors_o = errors;

  always @(posedge clk_i) begin
    pend_t                   p;
    simd_alu_pkg::alu_resp_t exp;
    if (arst_n_i) begin
      cyc = cyc + 1;
      if (req_valid_i) begin
        if (!seen_req) begin
          first_req_cyc = cyc;
          seen_req      = 1'b1;
        end
        pend_q.push_back('{req: req_i, rm: rm_model, tid: test_id_i});
      end
      if (req_credit_i) begin
        credit_count_o <= credit_count_o + 1;
      end
      if (resp_valid_i) begin
        resp_count_o <= resp_count_o + 1;
        if (!seen_resp && cyc != first_req_cyc + 2) begin
          errors = errors + 1;
          $display("FAIL first_response latency expected 2 actual %0d",
                   cyc - first_req_cyc);
        end
        seen_resp = 1'b1;
        if (pend_q.size() == 0) begin
          errors = errors + 1;
          $display("Response arrived with no request outstanding");
        end else begin
          p   = pend_q.pop_front();
          exp = model(p.req, p.rm);
          if (resp_i !== exp) begin
            errors = errors + 1;
            $display("FAIL %s op %0d vew %0d expected %h actual %h", test_name(p.tid),
                     p.req.op, p.req.vew, exp, resp_i);
          end
          sticky = sticky | (|exp.vxsat);
        end
      end
      if (vxsat_i !== sticky) begin
        errors = errors + 1;
        $display("FAIL vxsat expected %0d actual %0d", sticky, vxsat_i);
      end
      if (cfg_we_i) begin
        rm_model = cfg_i.vxrm;
        if (cfg_i.vxsat_clr) begin
          sticky = 1'b0;
        end
      end
    end
  end

endmodule

// ==== verif/simd_alu_asserts.sv ====
// Concurrent checks on credit and occupancy rules, bound into the queue and result stage
`timescale 1ns/1ns

module simd_alu_asserts #(
  parameter int unsigned Limit = 4
) (
  input logic       clk_i,
  input logic       arst_n_i,
  input logic       event_i,
  input logic       blocked_i,
  input logic [7:0] count_i
);

  // Push into a full queue, or a response without a credit
  assert property (@(posedge clk_i) disable iff (!arst_n_i) event_i |-> !blocked_i)
    else $error("event while blocked (push into full queue or response without credit)");

  assert property (@(posedge clk_i) disable iff (!arst_n_i) count_i <= 8'(Limit))
    else $error("count above its limit of %0d", Limit);

endmodule

bind op_queue simd_alu_asserts #(
  .Limit (QueueDepth)
) queue_asserts (
  .clk_i     (clk_i),
  .arst_n_i  (arst_n_i),
  .event_i   (push_i),
  .blocked_i (count_q == CntW'(QueueDepth)),
  .count_i   (8'(count_q))
);

bind result_stage simd_alu_asserts #(
  .Limit (OutCredits)
) credit_asserts (
  .clk_i     (clk_i),
  .arst_n_i  (arst_n_i),
  .event_i   (resp_valid_q),
  .blocked_i (credit_q == '0),
  .count_i   (8'(credit_q))
);

// ==== verif/tb_simd_alu.sv ====
// Testbench top for the SIMD ALU with random requests under credit flow on both sides
`timescale 1ns/1ns

module tb_simd_alu;

  localparam int QueueDepth = 4;
  localparam int OutCredits = 2;
  localparam int NumReqs    = 288;
  localparam int CycleLimit = 40 * NumReqs + 200;

  logic                    clk;
  logic                    arst_n;
  logic                    req_valid_i;
  simd_alu_pkg::alu_req_t  req_i;
  logic                    req_credit_o;
  logic                    resp_valid_o;
  simd_alu_pkg::alu_resp_t resp_o;
  logic                    resp_credit_i;
  logic                    cfg_we_i;
  simd_alu_pkg::cfg_t      cfg_i;
  logic                    vxsat_o;
  logic [1:0]              test_id;
  logic [15:0]             stim_lfsr;
  logic [15:0]             cr_lfsr;
  int                      sent;
  int                      ret_cnt;
  int                      cycles;
  int                      tb_errors;
  int                      chk_errors;
  int                      chk_resp;
  int                      chk_credits;
  int                      pending;

  simd_alu_top #(
    .QueueDepth (QueueDepth),
    .OutCredits (OutCredits)
  ) dut0 (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .req_credit_o  (req_credit_o),
    .resp_valid_o  (resp_valid_o),
    .resp_o        (resp_o),
    .resp_credit_i (resp_credit_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_i         (cfg_i),
    .vxsat_o       (vxsat_o)
  );

  alu_checker chk0 (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .test_id_i      (test_id),
    .cfg_we_i       (cfg_we_i),
    .cfg_i          (cfg_i),
    .resp_valid_i   (resp_valid_o),
    .resp_i         (resp_o),
    .req_credit_i   (req_credit_o),
    .vxsat_i        (vxsat_o),
    .errors_o       (chk_errors),
    .resp_count_o   (chk_resp),
    .credit_count_o (chk_credits)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] next_lfsr(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v         = {v[62:0], stim_lfsr[15]};
      stim_lfsr = next_lfsr(stim_lfsr);
    end
  endtask

  // Pushes element MSBs toward the signed and unsigned limits
  task automatic make_biased(input simd_alu_pkg::vew_e vw, output logic [63:0] v);
    logic [63:0] r;
    logic [63:0] m;
    logic [63:0] msb;
    logic [63:0] nxt;
    int          w;
    w   = 8 << vw;
    msb = '0;
    nxt = '0;
    for (int i = 0; i < 64 / w; i++) begin
      msb[i*w+w-1] = 1'b1;
      nxt[i*w+w-2] = 1'b1;
    end
    take_bits(64, r);
    take_bits(2, m);
    case (m[1:0])
      2'd0:    v = r | msb | nxt;
      2'd1:    v = (r & ~msb) | nxt;
      2'd2:    v = (r | msb) & ~nxt;
      default: v = r;
    endcase
  endtask

  task automatic send(input simd_alu_pkg::alu_op_e op, input simd_alu_pkg::vew_e vw,
                      input logic [63:0] a, input logic [63:0] b, input logic [1:0] tid);
    simd_alu_pkg::alu_req_t r;
    r.op  = op;
    r.vew = vw;
    r.opa = a;
    r.opb = b;
    while (sent - ret_cnt >= QueueDepth) begin
      req_valid_i <= 1'b0;
      @(posedge clk);
    end
    req_valid_i <= 1'b1;
    req_i       <= r;
    test_id     <= tid;
    sent = sent + 1;
    @(posedge clk);
  endtask

  task automatic wait_idle();
    req_valid_i <= 1'b0;
    while (chk_resp != sent) begin
      @(posedge clk);
    end
    @(posedge clk);
  endtask

  task automatic write_cfg(input simd_alu_pkg::vxrm_e rm, input logic clr);
    cfg_we_i <= 1'b1;
    cfg_i    <= '{vxrm: rm, vxsat_clr: clr};
    @(posedge clk);
    cfg_we_i <= 1'b0;
    @(posedge clk);
  endtask

  task automatic run_ops(input int first, input int last, input int per_width,
                         input logic biased, input logic [1:0] tid);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] sel;
    for (int k = first; k <= last; k++) begin
      for (int vw = 0; vw < 4; vw++) begin
        for (int i = 0; i < per_width; i++) begin
          if (biased) begin
            make_biased(simd_alu_pkg::vew_e'(vw), a);
            make_biased(simd_alu_pkg::vew_e'(vw), b);
          end else begin
            take_bits(64, a);
            take_bits(64, b);
            take_bits(2, sel);
            // Equal elements now and then for the compares
            if (sel[1:0] == 2'd0) begin
              b = a ^ {56'd0, b[7:0]};
            end
          end
          send(simd_alu_pkg::alu_op_e'(k), simd_alu_pkg::vew_e'(vw), a, b, tid);
        end
      end
    end
  endtask

  // Downstream returns credits after a random delay
  always @(posedge clk or negedge arst_n) begin
    logic [1:0] r;
    if (!arst_n) begin
      pending = 0;
      cr_lfsr = 16'd20;
      resp_credit_i <= 1'b0;
    end else begin
      if (resp_valid_o) begin
        pending = pending + 1;
      end
      r       = {cr_lfsr[15], 1'b0};
      cr_lfsr = next_lfsr(cr_lfsr);
      r[0]    = cr_lfsr[15];
      cr_lfsr = next_lfsr(cr_lfsr);
      if (pending > 0 && r != 2'd0) begin
        pending = pending - 1;
        resp_credit_i <= 1'b1;
      end else begin
        resp_credit_i <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    if (req_credit_o) begin
      ret_cnt <= ret_cnt + 1;
    end
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("Timeout after %0d cycles, %0d of %0d responses seen", cycles, chk_resp, sent);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    arst_n        = 1'b0;
    req_valid_i   = 1'b0;
    req_i         = '0;
    resp_credit_i = 1'b0;
    cfg_we_i      = 1'b0;
    cfg_i         = '0;
    test_id       = '0;
    stim_lfsr     = 16'd20;
    sent          = 0;
    ret_cnt       = 0;
    cycles        = 0;
    tb_errors     = 0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    // Idle stretch where the checker flags any stray response
    repeat (10) @(posedge clk);

    run_ops(int'(simd_alu_pkg::VADD), int'(simd_alu_pkg::VRSUB), 4, 1'b0, 2'd0);
    wait_idle();

    run_ops(int'(simd_alu_pkg::VSADDU), int'(simd_alu_pkg::VSSUB), 4, 1'b1, 2'd1);
    wait_idle();
    if (vxsat_o !== 1'b1) begin
      tb_errors++;
      $display("FAIL saturate vxsat after saturating ops expected 1 actual %b", vxsat_o);
    end
    write_cfg(simd_alu_pkg::RNU, 1'b1);
    if (vxsat_o !== 1'b0) begin
      tb_errors++;
      $display("FAIL saturate vxsat after clear write expected 0 actual %b", vxsat_o);
    end

    for (int rm = 0; rm < 4; rm++) begin
      write_cfg(simd_alu_pkg::vxrm_e'(rm), 1'b0);
      run_ops(int'(simd_alu_pkg::VAADDU), int'(simd_alu_pkg::VAADD), 3, 1'b0, 2'd2);
      wait_idle();
    end

    run_ops(int'(simd_alu_pkg::VAND), int'(simd_alu_pkg::VMSLT), 2, 1'b0, 2'd3);
    wait_idle();
    repeat (5) @(posedge clk);

    if (chk_credits != sent || chk_resp != sent) begin
      tb_errors++;
      $display("Counts disagree: %0d sent, %0d responses, %0d upstream credits",
               sent, chk_resp, chk_credits);
    end
    $display("Requests %0d, responses %0d, checker errors %0d, testbench errors %0d",
             sent, chk_resp, chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
source/simd_alu_pkg.sv
source/alu_csr.sv
source/op_queue.sv
source/simd_adder.sv
source/simd_logic_cmp.sv
source/result_stage.sv
source/simd_alu_top.sv
verif/simd_alu_asserts.sv
verif/alu_checker.sv
verif/tb_simd_alu.sv
